/* design/algo_1r1w_params.svh */
// size macros for the 1R1W memory built from single-port banks
`ifndef ALGO_1R1W_PARAMS_SVH
`define ALGO_1R1W_PARAMS_SVH

// data word width in bits
`define MEM_WIDTH    32

// four virtual banks spread over five physical banks
`define MEM_NUMVBNK  4
`define MEM_NUMPBNK  5

// rows per bank and logical words
`define MEM_NUMSROW  16
`define MEM_NUMADDR  64

// cycles from an accepted read to rd_vld
`define MEM_RD_LAT   2

`endif

/* design/algo_1r1w_pkg.sv */
// address, row, bank, data and physical address types of the 1R1W memory
`include "algo_1r1w_params.svh"

package algo_1r1w_pkg;

  localparam int ADR_W  = $clog2(`MEM_NUMADDR);
  localparam int ROW_W  = $clog2(`MEM_NUMSROW);
  localparam int VBNK_W = $clog2(`MEM_NUMVBNK);
  localparam int PBNK_W = $clog2(`MEM_NUMPBNK);

  // logical address, the low bits select the virtual bank
  typedef logic [ADR_W-1:0] adr_t;

  typedef logic [ROW_W-1:0] row_t;

  typedef logic [VBNK_W-1:0] vbnk_t;

  typedef logic [PBNK_W-1:0] pbnk_t;

  typedef logic [`MEM_WIDTH-1:0] data_t;

  // physical bank in the upper bits, row below it
  typedef logic [PBNK_W+ROW_W-1:0] padr_t;

endpackage

/* design/bank_port_if.sv */
// read and write commands from the scheduler to the physical banks
interface bank_port_if;
  import algo_1r1w_pkg::*;

  logic  rd_en;
  pbnk_t rd_bank;
  row_t  rd_row;

  logic  wr_en;
  pbnk_t wr_bank;
  row_t  wr_row;
  data_t wr_data;

  // the scheduler issues at most one read and one write per cycle
  modport sched (
    output rd_en, rd_bank, rd_row,
    output wr_en, wr_bank, wr_row, wr_data
  );

  modport banks (
    input rd_en, rd_bank, rd_row,
    input wr_en, wr_bank, wr_row, wr_data
  );

endinterface

/* design/map_table.sv */
// per-row virtual to physical bank map and free bank register, with reset sweep and swap
`include "algo_1r1w_params.svh"

module map_table (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  algo_1r1w_pkg::row_t                           rd_row,
  input  algo_1r1w_pkg::row_t                           wr_row,
  input  algo_1r1w_pkg::vbnk_t                          wr_vbnk,
  output algo_1r1w_pkg::pbnk_t [`MEM_NUMVBNK-1:0]       rd_map,
  output algo_1r1w_pkg::pbnk_t                          wr_pbnk,
  output algo_1r1w_pkg::pbnk_t                          wr_free,
  input  logic                                          swap_en,
  input  algo_1r1w_pkg::row_t                           swap_row,
  input  algo_1r1w_pkg::vbnk_t                          swap_vbnk,
  input  algo_1r1w_pkg::pbnk_t                          swap_pbnk,
  output logic                                          map_ready
);
  import algo_1r1w_pkg::*;

  pbnk_t [`MEM_NUMVBNK-1:0] map_q [`MEM_NUMSROW];
  pbnk_t                    free_q [`MEM_NUMSROW];
  row_t                     init_row;

  // sweep one row per cycle after reset, ready once the last row is written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_row  <= '0;
      map_ready <= 1'b0;
    end else if (!map_ready) begin
      init_row <= init_row + 1'b1;
      if (init_row == row_t'(`MEM_NUMSROW - 1)) begin
        map_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!map_ready) begin
      // identity mapping, the extra physical bank starts out free
      for (int v = 0; v < `MEM_NUMVBNK; v++) begin
        map_q[init_row][v] <= pbnk_t'(v);
      end
      free_q[init_row] <= pbnk_t'(`MEM_NUMVBNK);
    end else if (swap_en) begin
      map_q[swap_row][swap_vbnk] <= swap_pbnk;
      free_q[swap_row]           <= map_q[swap_row][swap_vbnk];
    end
  end

  assign rd_map  = map_q[rd_row];
  assign wr_pbnk = map_q[wr_row][wr_vbnk];
  assign wr_free = free_q[wr_row];

  // every swap must keep the free bank distinct from all mapped banks of its row
  for (genvar r = 0; r < `MEM_NUMSROW; r++) begin : g_chk_row
    for (genvar v = 0; v < `MEM_NUMVBNK; v++) begin : g_chk_vbnk
      a_free_unique: assert property (
        @(posedge clk) disable iff (!rst_n)
        map_ready |-> (free_q[r] != map_q[r][v])
      );
    end
  end

endmodule

/* design/bank_scheduler.sv */
// address decode, map lookup and write redirection on physical bank conflicts
`include "algo_1r1w_params.svh"

module bank_scheduler (
  input  logic                                          read,
  input  logic                                          write,
  input  algo_1r1w_pkg::adr_t                           rd_adr,
  input  algo_1r1w_pkg::adr_t                           wr_adr,
  input  algo_1r1w_pkg::data_t                          din,
  input  logic                                          map_ready,
  output algo_1r1w_pkg::row_t                           rd_row,
  output algo_1r1w_pkg::row_t                           wr_row,
  output algo_1r1w_pkg::vbnk_t                          wr_vbnk,
  input  algo_1r1w_pkg::pbnk_t [`MEM_NUMVBNK-1:0]       rd_map,
  input  algo_1r1w_pkg::pbnk_t                          wr_pbnk,
  input  algo_1r1w_pkg::pbnk_t                          wr_free,
  output logic                                          swap_en,
  output algo_1r1w_pkg::row_t                           swap_row,
  output algo_1r1w_pkg::vbnk_t                          swap_vbnk,
  output algo_1r1w_pkg::pbnk_t                          swap_pbnk,
  bank_port_if.sched                                    bport
);
  import algo_1r1w_pkg::*;

  vbnk_t rd_vbnk;
  pbnk_t rd_pbnk;
  logic  rd_act;
  logic  wr_act;
  logic  conflict;

  // low address bits pick the virtual bank, the rest is the row
  assign rd_vbnk = rd_adr[VBNK_W-1:0];
  assign rd_row  = rd_adr[ADR_W-1:VBNK_W];
  assign wr_vbnk = wr_adr[VBNK_W-1:0];
  assign wr_row  = wr_adr[ADR_W-1:VBNK_W];

  // commands are ignored until the map sweep is done
  assign rd_act = read && map_ready;
  assign wr_act = write && map_ready;

  assign rd_pbnk = rd_map[rd_vbnk];

  // the read keeps its bank, a colliding write moves to the free bank of its row
  assign conflict = rd_act && wr_act && (wr_pbnk == rd_pbnk);

  assign bport.rd_en   = rd_act;
  assign bport.rd_bank = rd_pbnk;
  assign bport.rd_row  = rd_row;

  assign bport.wr_en   = wr_act;
  assign bport.wr_bank = conflict ? wr_free : wr_pbnk;
  assign bport.wr_row  = wr_row;
  assign bport.wr_data = din;

  assign swap_en   = conflict;
  assign swap_row  = wr_row;
  assign swap_vbnk = wr_vbnk;
  assign swap_pbnk = wr_free;

  // relies on the map table never handing out a free bank that is also mapped
  always_comb begin
    if (bport.rd_en && bport.wr_en) begin
      a_no_bank_clash: assert final (bport.wr_bank != bport.rd_bank);
    end
  end

endmodule

/* design/bank_array.sv */
// five single-port banks with read pipeline, output select and physical address
`include "algo_1r1w_params.svh"

module bank_array (
  input  logic                  clk,
  input  logic                  rst_n,
  bank_port_if.banks            bport,
  output logic                  rd_vld,
  output algo_1r1w_pkg::data_t  rd_dout,
  output algo_1r1w_pkg::padr_t  rd_padr
);
  import algo_1r1w_pkg::*;

  localparam int LAT = `MEM_RD_LAT;

  logic  vld_q [LAT];
  pbnk_t bnk_q [LAT];
  row_t  row_q [LAT];
  data_t bank_dout [`MEM_NUMPBNK];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < LAT; i++) begin
        vld_q[i] <= 1'b0;
      end
      rd_vld <= 1'b0;
    end else begin
      vld_q[0] <= bport.rd_en;
      for (int i = 1; i < LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
      rd_vld <= vld_q[LAT-1];
    end
  end

  // read bank and row travel with the data so the output can be selected and tagged
  always_ff @(posedge clk) begin
    bnk_q[0] <= bport.rd_bank;
    row_q[0] <= bport.rd_row;
    for (int i = 1; i < LAT; i++) begin
      bnk_q[i] <= bnk_q[i-1];
      row_q[i] <= row_q[i-1];
    end
    if (vld_q[LAT-1]) begin
      rd_dout <= bank_dout[bnk_q[LAT-1]];
      rd_padr <= {bnk_q[LAT-1], row_q[LAT-1]};
    end
  end

  for (genvar b = 0; b < `MEM_NUMPBNK; b++) begin : g_bank
    data_t mem [`MEM_NUMSROW];
    data_t dout_q;
    logic  rd_sel;
    logic  wr_sel;
    logic  rd_q;

    assign rd_sel = bport.rd_en && (bport.rd_bank == pbnk_t'(b));
    assign wr_sel = bport.wr_en && (bport.wr_bank == pbnk_t'(b));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_q <= 1'b0;
      end else begin
        rd_q <= rd_sel;
      end
    end

    // the port takes the write now, a read flops its row and drives data out next cycle
    always_ff @(posedge clk) begin
      if (wr_sel) begin
        mem[bport.wr_row] <= bport.wr_data;
      end
      if (rd_q) begin
        dout_q <= mem[row_q[0]];
      end
    end

    assign bank_dout[b] = dout_q;

    a_single_port: assert property (
      @(posedge clk) disable iff (!rst_n) !(rd_sel && wr_sel)
    );
  end

endmodule

/* design/algo_1r1w_top.sv */
// top level of the 1R1W memory with map table, scheduler and bank array
`include "algo_1r1w_params.svh"

module algo_1r1w_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  read,
  input  logic                  write,
  input  algo_1r1w_pkg::adr_t   rd_adr,
  input  algo_1r1w_pkg::adr_t   wr_adr,
  input  algo_1r1w_pkg::data_t  din,
  output logic                  ready,
  output logic                  rd_vld,
  output algo_1r1w_pkg::data_t  rd_dout,
  output algo_1r1w_pkg::padr_t  rd_padr
);
  import algo_1r1w_pkg::*;

  row_t                     rd_row;
  row_t                     wr_row;
  vbnk_t                    wr_vbnk;
  pbnk_t [`MEM_NUMVBNK-1:0] rd_map;
  pbnk_t                    wr_pbnk;
  pbnk_t                    wr_free;
  logic                     swap_en;
  row_t                     swap_row;
  vbnk_t                    swap_vbnk;
  pbnk_t                    swap_pbnk;

  bank_port_if bport ();

  map_table u_map (
    .clk(clk), .rst_n(rst_n),
    .rd_row(rd_row), .wr_row(wr_row), .wr_vbnk(wr_vbnk),
    .rd_map(rd_map), .wr_pbnk(wr_pbnk), .wr_free(wr_free),
    .swap_en(swap_en), .swap_row(swap_row), .swap_vbnk(swap_vbnk), .swap_pbnk(swap_pbnk),
    .map_ready(ready)
  );

  bank_scheduler u_sched (
    .read(read), .write(write), .rd_adr(rd_adr), .wr_adr(wr_adr), .din(din),
    .map_ready(ready),
    .rd_row(rd_row), .wr_row(wr_row), .wr_vbnk(wr_vbnk),
    .rd_map(rd_map), .wr_pbnk(wr_pbnk), .wr_free(wr_free),
    .swap_en(swap_en), .swap_row(swap_row), .swap_vbnk(swap_vbnk), .swap_pbnk(swap_pbnk),
    .bport(bport.sched)
  );

  bank_array u_banks (
    .clk(clk), .rst_n(rst_n),
    .bport(bport.banks),
    .rd_vld(rd_vld), .rd_dout(rd_dout), .rd_padr(rd_padr)
  );

endmodule

/* test/algo_1r1w_tb.sv */
// testbench for the 1R1W memory with a reference model, directed tests and a timeout
`include "algo_1r1w_params.svh"

module algo_1r1w_tb;
  import algo_1r1w_pkg::*;

  // the tests need about 570 cycles
  localparam int TIMEOUT_CYCLES = 3000;

  typedef struct packed {
    logic  vld;
    data_t data;
    padr_t padr;
  } rd_exp_t;

  logic  clk;
  logic  rst_n;
  logic  read;
  logic  write;
  adr_t  rd_adr;
  adr_t  wr_adr;
  data_t din;
  logic  ready;
  logic  rd_vld;
  data_t rd_dout;
  padr_t rd_padr;

  data_t   ref_mem [`MEM_NUMADDR];
  pbnk_t   ref_map [`MEM_NUMSROW][`MEM_NUMVBNK];
  pbnk_t   ref_free [`MEM_NUMSROW];
  rd_exp_t exp_q [$];
  string   test_name;
  int      cycle_count = 0;

  algo_1r1w_top DUT (
    .clk(clk), .rst_n(rst_n), .read(read), .write(write),
    .rd_adr(rd_adr), .wr_adr(wr_adr), .din(din),
    .ready(ready), .rd_vld(rd_vld), .rd_dout(rd_dout), .rd_padr(rd_padr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout: tests still running after %0d cycles", cycle_count));
    end
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string what, input data_t exp_val, input data_t act_val);
    stop_with_failure($sformatf("[ERROR] %s: %s expected %h, actual %h",
                                test_name, what, exp_val, act_val));
  endtask

  task automatic check_read(input rd_exp_t exp_r);
    assert (rd_vld === exp_r.vld)
      else report_mismatch("rd_vld", data_t'(exp_r.vld), data_t'(rd_vld));
    if (exp_r.vld) begin
      assert (rd_dout === exp_r.data) else report_mismatch("rd_dout", exp_r.data, rd_dout);
      assert (rd_padr === exp_r.padr)
        else report_mismatch("rd_padr", data_t'(exp_r.padr), data_t'(rd_padr));
    end
  endtask

  // one cycle: drive the inputs, update the model, then check the read due at this edge
  task automatic drive_cycle(input logic rd, input adr_t ra, input logic wr, input adr_t wa,
                             input data_t d);
    rd_exp_t exp_now;
    row_t    rrow;
    row_t    wrow;
    pbnk_t   rpb;
    pbnk_t   wpb;
    read   = rd;
    rd_adr = ra;
    write  = wr;
    wr_adr = wa;
    din    = d;
    rrow    = row_t'(ra / `MEM_NUMVBNK);
    wrow    = row_t'(wa / `MEM_NUMVBNK);
    rpb     = ref_map[rrow][ra % `MEM_NUMVBNK];
    wpb     = ref_map[wrow][wa % `MEM_NUMVBNK];
    exp_now = '0;
    if (rd) begin
      exp_now.vld  = 1'b1;
      exp_now.data = ref_mem[ra];
      exp_now.padr = {rpb, rrow};
    end
    if (wr) begin
      // a write on the read's bank moves to the free bank and its old bank becomes free
      if (rd && wpb == rpb) begin
        ref_map[wrow][wa % `MEM_NUMVBNK] = ref_free[wrow];
        ref_free[wrow] = wpb;
      end
      ref_mem[wa] = d;
    end
    @(posedge clk);
    #1;
    exp_q.push_back(exp_now);
    if (exp_q.size() > `MEM_RD_LAT) begin
      check_read(exp_q.pop_front());
    end
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic test_ready();
    test_name = "test_ready";
    rst_n = 1'b0;
    repeat (8) begin
      @(posedge clk);
      #1;
      assert (ready === 1'b0) else report_mismatch("ready in reset", '0, data_t'(ready));
      assert (rd_vld === 1'b0) else report_mismatch("rd_vld in reset", '0, data_t'(rd_vld));
    end
    rst_n = 1'b1;
    for (int k = 1; k <= 20; k++) begin
      idle_cycle();
      assert (ready === (k >= `MEM_NUMSROW))
        else report_mismatch("ready", data_t'(k >= `MEM_NUMSROW), data_t'(ready));
      assert (rd_vld === 1'b0) else report_mismatch("rd_vld", '0, data_t'(rd_vld));
    end
  endtask

  // the map is still the identity here, so every rd_padr carries the virtual bank
  task automatic test_write_read();
    test_name = "test_write_read";
    for (int a = 0; a < `MEM_NUMADDR; a++) begin
      drive_cycle(1'b0, '0, 1'b1, adr_t'(a), data_t'($urandom));
    end
    for (int a = 0; a < `MEM_NUMADDR; a++) begin
      drive_cycle(1'b1, adr_t'(a), 1'b0, '0, '0);
    end
    repeat (`MEM_RD_LAT) idle_cycle();
  endtask

  task automatic test_conflict();
    data_t new_val;
    test_name = "test_conflict";
    new_val   = data_t'($urandom);
    // address 9 is row 2 and address 21 is row 5, both on physical bank 1
    drive_cycle(1'b1, adr_t'(9), 1'b1, adr_t'(21), new_val);
    drive_cycle(1'b1, adr_t'(21), 1'b0, '0, '0);
    repeat (`MEM_RD_LAT) idle_cycle();
    assert (rd_padr === {pbnk_t'(`MEM_NUMVBNK), row_t'(5)})
      else report_mismatch("moved rd_padr", data_t'({3'd4, 4'd5}), data_t'(rd_padr));
    assert (rd_dout === new_val) else report_mismatch("moved rd_dout", new_val, rd_dout);
  endtask

  task automatic test_same_address();
    data_t old_val;
    data_t new_val;
    test_name = "test_same_address";
    old_val   = ref_mem[30];
    new_val   = ~old_val;
    drive_cycle(1'b1, adr_t'(30), 1'b1, adr_t'(30), new_val);
    drive_cycle(1'b1, adr_t'(30), 1'b0, '0, '0);
    idle_cycle();
    assert (rd_dout === old_val) else report_mismatch("old rd_dout", old_val, rd_dout);
    idle_cycle();
    assert (rd_dout === new_val) else report_mismatch("new rd_dout", new_val, rd_dout);
  endtask

  task automatic test_random_traffic();
    test_name = "test_random_traffic";
    for (int i = 0; i < 400; i++) begin
      drive_cycle($urandom_range(0, 3) != 0, adr_t'($urandom_range(0, `MEM_NUMADDR - 1)),
                  $urandom_range(0, 3) != 0, adr_t'($urandom_range(0, `MEM_NUMADDR - 1)),
                  data_t'($urandom));
    end
    repeat (`MEM_RD_LAT) idle_cycle();
  endtask

  initial begin
    rst_n  = 1'b0;
    read   = 1'b0;
    write  = 1'b0;
    rd_adr = '0;
    wr_adr = '0;
    din    = '0;
    void'($urandom(85));
    for (int r = 0; r < `MEM_NUMSROW; r++) begin
      for (int v = 0; v < `MEM_NUMVBNK; v++) begin
        ref_map[r][v] = pbnk_t'(v);
      end
      ref_free[r] = pbnk_t'(`MEM_NUMVBNK);
    end
    test_ready();
    test_write_read();
    test_conflict();
    test_same_address();
    test_random_traffic();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* algo_1r1w.f */
+incdir+design
design/algo_1r1w_pkg.sv
design/bank_port_if.sv
design/map_table.sv
design/bank_scheduler.sv
design/bank_array.sv
design/algo_1r1w_top.sv
test/algo_1r1w_tb.sv

/* Makefile */
# Verilator build and run of the 1R1W memory testbench

VERILATOR ?= verilator
TOP       ?= algo_1r1w_tb
FILELIST  ?= algo_1r1w.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) design/algo_1r1w_params.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
